//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := sched_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/sched_alloc.sv
module sched_alloc #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                 i_disp_valid,
  input  logic [ENTRY_NUM-1:0] i_entry_valid,
  output logic [ENTRY_NUM-1:0] o_put,
  output logic                 o_full
);

  logic [ENTRY_NUM-1:0] w_free;
  logic [ENTRY_NUM-1:0] w_sel;
  logic                 w_found;

  assign w_free = ~i_entry_valid;

  // priority encoder, lowest free index wins
  always_comb begin
    w_sel   = '0;
    w_found = 1'b0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (w_free[i] && !w_found) begin
        w_sel[i] = 1'b1;
        w_found  = 1'b1;
      end
    end
  end

  // steer dispatch into the selected entry
  assign o_put  = i_disp_valid ? w_sel : '0;
  assign o_full = &i_entry_valid;

endmodule

//--- source/sched_entry.sv
module sched_entry
  import sched_pkg::*;
#(
  parameter int ENTRY_INDEX = 0
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_put,
  input  disp_t            i_disp,

  input  phy_wr_t          i_phy_wr [WR_BUS_NUM],
  input  logic             i_picked,

  input  done_t            i_done,
  input  logic             i_replay_valid,
  input  logic [IDX_W-1:0] i_replay_index,
  input  commit_t          i_commit,

  output logic             o_valid,
  output logic             o_ready,
  output issue_t           o_issue,
  output logic             o_finish,
  output cmt_id_t          o_cmt_id,
  output logic             o_except_valid
);

  localparam logic [IDX_W-1:0] MY_INDEX = IDX_W'(ENTRY_INDEX);

  entry_state_t r_state;
  disp_t        r_disp;
  logic         r_rs1_ready;
  logic         r_rs2_ready;
  logic         r_except;

  rnid_t w_rs1_rnid;
  rnid_t w_rs2_rnid;
  logic  w_rs1_hit;
  logic  w_rs2_hit;
  logic  w_rs1_ok;
  logic  w_rs2_ok;

  logic  w_flush;
  logic  w_commit_hit;
  logic  w_flush_entry;
  logic  w_replay_hit;
  logic  w_done_hit;
  logic  w_done_take;

  // tags from dispatch during put, so a same-cycle write is caught
  assign w_rs1_rnid = i_put ? i_disp.rs1_rnid : r_disp.rs1_rnid;
  assign w_rs2_rnid = i_put ? i_disp.rs2_rnid : r_disp.rs2_rnid;

  sched_tag_match u_rs1_match (
    .i_rnid   (w_rs1_rnid),
    .i_phy_wr (i_phy_wr),
    .o_hit    (w_rs1_hit)
  );

  sched_tag_match u_rs2_match (
    .i_rnid   (w_rs2_rnid),
    .i_phy_wr (i_phy_wr),
    .o_hit    (w_rs2_hit)
  );

  assign w_flush      = i_commit.valid & i_commit.flush;
  assign w_commit_hit = i_commit.valid & (r_state == ST_WAIT_COMMIT) &
                        (i_commit.cmt_id == r_disp.cmt_id);
  assign w_flush_entry = w_flush & o_valid & !w_commit_hit;

  assign w_replay_hit = i_replay_valid & (i_replay_index == MY_INDEX);
  assign w_done_hit   = i_done.valid & (i_done.index == MY_INDEX);
  // replay wins over done
  assign w_done_take  = (r_state == ST_ISSUED) & !w_flush_entry & !w_replay_hit & w_done_hit;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_FREE;
    end else begin
      case (r_state)
        ST_FREE: begin
          if (i_put) r_state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (w_flush_entry) begin
            r_state <= ST_FREE;
          end else if (i_picked && o_ready) begin
            r_state <= ST_ISSUED;
          end
        end
        ST_ISSUED: begin
          if (w_flush_entry) begin
            r_state <= ST_FREE;
          end else if (w_replay_hit) begin
            r_state <= ST_WAIT;  // back to waiting, sources stay ready
          end else if (w_done_hit) begin
            r_state <= ST_DONE;
          end
        end
        ST_DONE: begin
          r_state <= w_flush_entry ? ST_FREE : ST_WAIT_COMMIT;
        end
        ST_WAIT_COMMIT: begin
          if (w_commit_hit || w_flush_entry) r_state <= ST_FREE;
        end
        default: begin
          r_state <= ST_FREE;
          $fatal(0, "sched_entry %0d: unknown state", ENTRY_INDEX);
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_disp      <= i_disp;
      r_rs1_ready <= w_rs1_hit;
      r_rs2_ready <= w_rs2_hit;
      r_except    <= 1'b0;
    end else begin
      if (r_state == ST_WAIT) begin
        r_rs1_ready <= r_rs1_ready | w_rs1_hit;
        r_rs2_ready <= r_rs2_ready | w_rs2_hit;
      end
      if (w_done_take) r_except <= i_done.except_valid;
    end
  end

  // an absent source counts as ready
  assign w_rs1_ok = !r_disp.rs1_valid | r_rs1_ready | w_rs1_hit;
  assign w_rs2_ok = !r_disp.rs2_valid | r_rs2_ready | w_rs2_hit;

  assign o_valid = (r_state != ST_FREE);
  assign o_ready = (r_state == ST_WAIT) & w_rs1_ok & w_rs2_ok & !w_flush;

  assign o_issue.index   = MY_INDEX;
  assign o_issue.cmt_id  = r_disp.cmt_id;
  assign o_issue.rd_rnid = r_disp.rd_rnid;
  assign o_issue.opcode  = r_disp.opcode;

  assign o_finish       = w_commit_hit;
  assign o_cmt_id       = r_disp.cmt_id;
  assign o_except_valid = r_except;

endmodule

//--- source/sched_pick.sv
module sched_pick
  import sched_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  logic [ENTRY_NUM-1:0] i_ready,
  input  issue_t               i_entry_issue [ENTRY_NUM],
  input  logic [ENTRY_NUM-1:0] i_finish,
  input  cmt_id_t              i_cmt_id [ENTRY_NUM],
  input  logic [ENTRY_NUM-1:0] i_except_valid,
  output logic [ENTRY_NUM-1:0] o_picked,
  output logic                 o_issue_valid,
  output issue_t               o_issue,
  output complete_t            o_complete
);

  logic w_taken;

  // fixed priority, lowest ready index issues
  always_comb begin
    o_picked = '0;
    o_issue  = '0;
    w_taken  = 1'b0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (i_ready[i] && !w_taken) begin
        o_picked[i] = 1'b1;
        o_issue     = i_entry_issue[i];
        w_taken     = 1'b1;
      end
    end
  end

  assign o_issue_valid = w_taken;

  // commit ids are unique, so at most one entry finishes
  always_comb begin
    o_complete = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (i_finish[i]) begin
        o_complete.valid        = 1'b1;
        o_complete.cmt_id       = i_cmt_id[i];
        o_complete.except_valid = i_except_valid[i];
      end
    end
  end

endmodule

//--- source/sched_pkg.sv
package sched_pkg;

  // physical register tag and commit id widths
  localparam int RNID_W     = 6;
  localparam int CMT_ID_W   = 5;
  localparam int WR_BUS_NUM = 2;

  localparam int OPC_W = 4;
  localparam int IDX_W = 8;  // covers the largest ENTRY_NUM

  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // entry lifetime
  typedef enum logic [2:0] {
    ST_FREE        = 3'd0,
    ST_WAIT        = 3'd1,
    ST_ISSUED      = 3'd2,
    ST_DONE        = 3'd3,
    ST_WAIT_COMMIT = 3'd4
  } entry_state_t;

  // renamed instruction from dispatch, 29 bits
  typedef struct packed {
    cmt_id_t          cmt_id;
    rnid_t            rd_rnid;
    logic             rs1_valid;
    rnid_t            rs1_rnid;
    logic             rs2_valid;
    rnid_t            rs2_rnid;
    logic [OPC_W-1:0] opcode;
  } disp_t;

  // write-back broadcast
  typedef struct packed {
    logic  valid;
    rnid_t rd_rnid;
  } phy_wr_t;

  typedef struct packed {
    logic [IDX_W-1:0] index;
    cmt_id_t          cmt_id;
    rnid_t            rd_rnid;
    logic [OPC_W-1:0] opcode;
  } issue_t;

  // pipe-done report, index names the entry
  typedef struct packed {
    logic             valid;
    logic [IDX_W-1:0] index;
    logic             except_valid;
  } done_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    flush;
  } commit_t;

  // towards the reorder buffer
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    except_valid;
  } complete_t;

endpackage

//--- source/sched_tag_match.sv
module sched_tag_match
  import sched_pkg::*;
(
  input  rnid_t   i_rnid,
  input  phy_wr_t i_phy_wr [WR_BUS_NUM],
  output logic    o_hit
);

  logic [WR_BUS_NUM-1:0] w_bus_hit;

  always_comb begin
    for (int b = 0; b < WR_BUS_NUM; b++) begin
      w_bus_hit[b] = i_phy_wr[b].valid && (i_phy_wr[b].rd_rnid == i_rnid);
    end
  end

  assign o_hit = |w_bus_hit;  // any bus carrying the tag

endmodule

//--- source/sched_top.sv
module sched_top
  import sched_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_disp_valid,
  input  disp_t            i_disp,
  input  phy_wr_t          i_phy_wr [WR_BUS_NUM],
  input  done_t            i_done,
  input  logic             i_replay_valid,
  input  logic [IDX_W-1:0] i_replay_index,
  input  commit_t          i_commit,

  output logic             o_full,
  output logic             o_issue_valid,
  output issue_t           o_issue,
  output complete_t        o_complete
);

  logic [ENTRY_NUM-1:0] w_put;
  logic [ENTRY_NUM-1:0] w_valid;
  logic [ENTRY_NUM-1:0] w_ready;
  logic [ENTRY_NUM-1:0] w_picked;
  logic [ENTRY_NUM-1:0] w_finish;
  logic [ENTRY_NUM-1:0] w_except_valid;
  issue_t               w_entry_issue [ENTRY_NUM];
  cmt_id_t              w_cmt_id [ENTRY_NUM];

  sched_alloc #(.ENTRY_NUM(ENTRY_NUM)) u_alloc (
    .i_disp_valid  (i_disp_valid),
    .i_entry_valid (w_valid),
    .o_put         (w_put),
    .o_full        (o_full)
  );

  for (genvar g = 0; g < ENTRY_NUM; g++) begin : g_entry
    sched_entry #(.ENTRY_INDEX(g)) u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_put[g]),
      .i_disp         (i_disp),
      .i_phy_wr       (i_phy_wr),
      .i_picked       (w_picked[g]),
      .i_done         (i_done),
      .i_replay_valid (i_replay_valid),
      .i_replay_index (i_replay_index),
      .i_commit       (i_commit),
      .o_valid        (w_valid[g]),
      .o_ready        (w_ready[g]),
      .o_issue        (w_entry_issue[g]),
      .o_finish       (w_finish[g]),
      .o_cmt_id       (w_cmt_id[g]),
      .o_except_valid (w_except_valid[g])
    );
  end

  sched_pick #(.ENTRY_NUM(ENTRY_NUM)) u_pick (
    .i_ready        (w_ready),
    .i_entry_issue  (w_entry_issue),
    .i_finish       (w_finish),
    .i_cmt_id       (w_cmt_id),
    .i_except_valid (w_except_valid),
    .o_picked       (w_picked),
    .o_issue_valid  (o_issue_valid),
    .o_issue        (o_issue),
    .o_complete     (o_complete)
  );

endmodule

//--- tb/sched_props.sv
module sched_props
  import sched_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input logic      i_clk,
  input logic      i_reset_n,
  input logic      i_disp_valid,
  input logic      o_full,
  input logic      o_issue_valid,
  input issue_t    o_issue,
  input complete_t o_complete,
  input commit_t   i_commit
);

  timeunit 1ns;
  timeprecision 100ps;

  a_no_disp_when_full: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) !(i_disp_valid && o_full)
  ) else $error("dispatch while the queue is full");

  a_issue_index_range: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_issue_valid |-> (o_issue.index < 8'(ENTRY_NUM))
  ) else $error("issued index out of range");

  // completion only comes from a commit
  a_complete_needs_commit: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_complete.valid |-> i_commit.valid
  ) else $error("completion without a commit");

  a_no_issue_after_reset: assert property (
    @(posedge i_clk) $rose(i_reset_n) |-> !o_issue_valid
  ) else $error("issue in the first cycle after reset");

endmodule

//--- tb/sched_tb.sv
module sched_tb
  import sched_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ENTRY_NUM    = 4;
  localparam int RESET_CYCLES = 2;

  // one table row, all inputs for one clock cycle
  typedef struct packed {
    logic             disp_valid;
    disp_t            disp;
    phy_wr_t          wr0;
    phy_wr_t          wr1;
    done_t            done;
    logic             replay_valid;
    logic [IDX_W-1:0] replay_index;
    commit_t          commit;
  } step_t;

  logic             clk;
  logic             reset_n;
  logic             disp_valid;
  disp_t            disp;
  phy_wr_t          phy_wr [WR_BUS_NUM];
  done_t            done;
  logic             replay_valid;
  logic [IDX_W-1:0] replay_index;
  commit_t          commit;
  logic             full;
  logic             issue_valid;
  issue_t           issue;
  complete_t        complete;

  step_t        steps[$];
  step_t        cur;
  int           n_rows;
  int           n_checks;
  int           n_errors;
  integer       seed;

  // reference model of the entry array
  entry_state_t m_st   [ENTRY_NUM];
  disp_t        m_disp [ENTRY_NUM];
  logic         m_rs1  [ENTRY_NUM];
  logic         m_rs2  [ENTRY_NUM];
  logic         m_exc  [ENTRY_NUM];

  sched_top #(.ENTRY_NUM(ENTRY_NUM)) dut (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_disp_valid   (disp_valid),
    .i_disp         (disp),
    .i_phy_wr       (phy_wr),
    .i_done         (done),
    .i_replay_valid (replay_valid),
    .i_replay_index (replay_index),
    .i_commit       (commit),
    .o_full         (full),
    .o_issue_valid  (issue_valid),
    .o_issue        (issue),
    .o_complete     (complete)
  );

  bind sched_top sched_props #(.ENTRY_NUM(ENTRY_NUM)) u_props (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .o_full        (o_full),
    .o_issue_valid (o_issue_valid),
    .o_issue       (o_issue),
    .o_complete    (o_complete),
    .i_commit      (i_commit)
  );

  always #5 clk = ~clk;

  function automatic logic bus_hit(rnid_t tag, step_t s);
    return (s.wr0.valid && s.wr0.rd_rnid == tag) || (s.wr1.valid && s.wr1.rd_rnid == tag);
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic set_disp(cmt_id_t c, rnid_t rd, logic v1, rnid_t s1, logic v2, rnid_t s2,
                          logic [3:0] op);
    cur.disp_valid = 1'b1;
    cur.disp       = '{c, rd, v1, s1, v2, s2, op};
  endtask

  task automatic set_wr(int bus, rnid_t tag);
    if (bus == 0) cur.wr0 = '{1'b1, tag};
    else cur.wr1 = '{1'b1, tag};
  endtask

  task automatic set_done(int idx, logic exc);
    cur.done = '{1'b1, IDX_W'(idx), exc};
  endtask

  task automatic set_replay(int idx);
    cur.replay_valid = 1'b1;
    cur.replay_index = IDX_W'(idx);
  endtask

  task automatic set_commit(cmt_id_t c, logic flush);
    cur.commit = '{1'b1, c, flush};
  endtask

  task automatic push_row();
    steps.push_back(cur);
    cur = '0;
  endtask

  // filler tags stay in 0x30..0x3f, above every source tag of the table
  task automatic fill_rows(int n);
    for (int k = 0; k < n; k++) begin
      cur.wr0 = '{1'b1, rnid_t'(6'h30 + 6'($random(seed) & 15))};
      cur.wr1 = '{1'b1, rnid_t'(6'h30 + 6'($random(seed) & 15))};
      push_row();
    end
  endtask

  task automatic build_table();
    cur = '0;
    set_disp(5'd1, 6'd20, 1'b1, 6'd10, 1'b0, 6'd0, 4'd1);
    push_row();
    set_disp(5'd2, 6'd21, 1'b1, 6'd11, 1'b1, 6'd12, 4'd2);
    push_row();
    set_disp(5'd3, 6'd22, 1'b1, 6'd13, 1'b0, 6'd0, 4'd3);
    set_wr(0, 6'd13);  // hit in the dispatch cycle
    push_row();
    set_disp(5'd4, 6'd23, 1'b0, 6'd0, 1'b0, 6'd0, 4'd4);
    push_row();
    set_wr(0, 6'd12);  // early wake of rs2 in entry 1
    push_row();        // full now
    set_wr(0, 6'd10);  // entries 0 and 1 ready together
    set_wr(1, 6'd11);
    push_row();
    set_done(2, 1'b0);
    push_row();
    set_done(3, 1'b1);
    set_replay(0);
    push_row();
    set_done(1, 1'b1); // replay wins here
    set_replay(1);
    push_row();
    set_commit(5'd3, 1'b0);
    push_row();
    set_commit(5'd4, 1'b0);
    set_disp(5'd5, 6'd24, 1'b1, 6'd14, 1'b0, 6'd0, 4'd5);
    push_row();
    set_commit(5'd9, 1'b0);  // matches nothing
    set_done(0, 1'b0);
    push_row();
    set_done(1, 1'b0);
    set_wr(0, 6'd14);
    push_row();
    set_disp(5'd6, 6'd25, 1'b1, 6'd15, 1'b0, 6'd0, 4'd6);
    set_commit(5'd1, 1'b0);
    push_row();
    set_commit(5'd2, 1'b1);
    set_wr(0, 6'd15);  // would wake entry 3, flush blocks it
    push_row();
    fill_rows(2);
    set_disp(5'd7, 6'd26, 1'b0, 6'd0, 1'b0, 6'd0, 4'd7);
    push_row();
    fill_rows(3);
  endtask

  task automatic apply(step_t s);
    disp_valid   = s.disp_valid;
    disp         = s.disp;
    phy_wr[0]    = s.wr0;
    phy_wr[1]    = s.wr1;
    done         = s.done;
    replay_valid = s.replay_valid;
    replay_index = s.replay_index;
    commit       = s.commit;
  endtask

  // compare outputs of this cycle, then step the model across the edge
  task automatic check_and_advance(step_t s);
    logic [ENTRY_NUM-1:0] ready;
    logic [ENTRY_NUM-1:0] chit;
    logic                 flush;
    logic                 fl_e;
    logic                 exp_full;
    int                   pick;
    int                   put_idx;
    issue_t               exp_i;
    complete_t            exp_c;
    flush    = s.commit.valid && s.commit.flush;
    pick     = -1;
    put_idx  = -1;
    exp_full = 1'b1;
    exp_i    = '0;
    exp_c    = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      chit[i]  = s.commit.valid && m_st[i] == ST_WAIT_COMMIT &&
                 m_disp[i].cmt_id == s.commit.cmt_id;
      ready[i] = m_st[i] == ST_WAIT && !flush &&
                 (!m_disp[i].rs1_valid || m_rs1[i] || bus_hit(m_disp[i].rs1_rnid, s)) &&
                 (!m_disp[i].rs2_valid || m_rs2[i] || bus_hit(m_disp[i].rs2_rnid, s));
      if (ready[i] && pick < 0) pick = i;
      if (m_st[i] == ST_FREE) begin
        exp_full = 1'b0;
        if (put_idx < 0) put_idx = i;
      end
      if (chit[i]) exp_c = '{1'b1, m_disp[i].cmt_id, m_exc[i]};
    end
    if (pick >= 0) begin
      exp_i.index   = IDX_W'(pick);
      exp_i.cmt_id  = m_disp[pick].cmt_id;
      exp_i.rd_rnid = m_disp[pick].rd_rnid;
      exp_i.opcode  = m_disp[pick].opcode;
    end
    check_value("o_full", 32'(full), 32'(exp_full));
    check_value("o_issue_valid", 32'(issue_valid), 32'(pick >= 0));
    if (pick >= 0) check_value("o_issue", 32'(issue), 32'(exp_i));
    check_value("o_complete", 32'(complete), 32'(exp_c));
    for (int i = 0; i < ENTRY_NUM; i++) begin
      fl_e = flush && m_st[i] != ST_FREE && !chit[i];
      case (m_st[i])
        ST_FREE: begin
          if (s.disp_valid && put_idx == i) begin
            m_st[i]   = ST_WAIT;
            m_disp[i] = s.disp;
            m_rs1[i]  = bus_hit(s.disp.rs1_rnid, s);
            m_rs2[i]  = bus_hit(s.disp.rs2_rnid, s);
            m_exc[i]  = 1'b0;
          end
        end
        ST_WAIT: begin
          m_rs1[i] = m_rs1[i] | bus_hit(m_disp[i].rs1_rnid, s);
          m_rs2[i] = m_rs2[i] | bus_hit(m_disp[i].rs2_rnid, s);
          if (fl_e) m_st[i] = ST_FREE;
          else if (pick == i) m_st[i] = ST_ISSUED;
        end
        ST_ISSUED: begin
          if (fl_e) begin
            m_st[i] = ST_FREE;
          end else if (s.replay_valid && s.replay_index == IDX_W'(i)) begin
            m_st[i] = ST_WAIT;
          end else if (s.done.valid && s.done.index == IDX_W'(i)) begin
            m_st[i]  = ST_DONE;
            m_exc[i] = s.done.except_valid;
          end
        end
        ST_DONE: m_st[i] = fl_e ? ST_FREE : ST_WAIT_COMMIT;
        ST_WAIT_COMMIT: begin
          if (chit[i] || fl_e) m_st[i] = ST_FREE;
        end
        default: m_st[i] = ST_FREE;
      endcase
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset_n  = 1'b0;
    n_rows   = 0;
    n_checks = 0;
    n_errors = 0;
    seed     = 32'hd6ea_a2b0;
    apply('0);
    for (int i = 0; i < ENTRY_NUM; i++) begin
      m_st[i]   = ST_FREE;
      m_disp[i] = '0;
      m_rs1[i]  = 1'b0;
      m_rs2[i]  = 1'b0;
      m_exc[i]  = 1'b0;
    end
    build_table();
    n_rows = steps.size();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      apply(steps[r]);
      #4;              // outputs settled mid cycle
      check_and_advance(steps[r]);
      @(posedge clk);
      #1;
    end
    apply('0);
    $display("checks run %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (n_rows > 0);
    #((n_rows + RESET_CYCLES + 10) * 10);
    $display("watchdog expired before the table was finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- verilog.f
source/sched_pkg.sv
source/sched_alloc.sv
source/sched_tag_match.sv
source/sched_entry.sv
source/sched_pick.sv
source/sched_top.sv
tb/sched_props.sv
tb/sched_tb.sv
